// File: hw/exec_params.svh
/* Execute stage parameters */
`ifndef EXEC_PARAMS_SVH
`define EXEC_PARAMS_SVH

// Datapath and register file sizes
`define DATA_W 16
`define REG_N 16
`define REG_IDX_W 4
`define SHAMT_W 4
`define IMM_W 8

// Instruction word fields
`define OPC_MSB 15
`define OPC_LSB 12
`define RD_MSB 11
`define RD_LSB 8
`define RS_MSB 7
`define RS_LSB 4
`define RT_MSB 3
`define RT_LSB 0
`define SHAMT_MSB 3
`define SHAMT_LSB 0
`define IMM_MSB 7
`define IMM_LSB 0

`endif

// File: hw/exec_pkg.sv
/* Execute stage types */
`include "exec_params.svh"

package exec_pkg;

	typedef logic [`DATA_W-1:0] word_t;
	typedef logic [`REG_IDX_W-1:0] reg_idx_t;
	typedef logic [`SHAMT_W-1:0] shamt_t;

	// Instruction opcodes
	typedef enum logic [`OPC_MSB-`OPC_LSB:0] {
		OP_ADD  = 4'b0000,
		OP_ADDZ = 4'b0001,
		OP_SUB  = 4'b0010,
		OP_AND  = 4'b0011,
		OP_NOR  = 4'b0100,
		OP_SLL  = 4'b0101,
		OP_SRL  = 4'b0110,
		OP_SRA  = 4'b0111,
		OP_LW   = 4'b1000,
		OP_SW   = 4'b1001,
		OP_LHB  = 4'b1010,
		OP_LLB  = 4'b1011,
		OP_B    = 4'b1100,
		OP_JAL  = 4'b1101,
		OP_JR   = 4'b1110,
		OP_HLT  = 4'b1111
	} opcode_e;

	// ALU operations
	typedef enum logic [2:0] {
		ADD16 = 3'b000,
		SUB16 = 3'b001,
		AND16 = 3'b010,
		NOR16 = 3'b011,
		SLL16 = 3'b100,
		SRL16 = 3'b101,
		LHB16 = 3'b110,
		SRA16 = 3'b111
	} alu_op_e;

endpackage

// File: hw/reg_file.sv
/* Register file */
`timescale 1ns/1ns
`include "exec_params.svh"

module reg_file import exec_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  reg_idx_t rd_addr_a,
	input  reg_idx_t rd_addr_b,
	output word_t    rd_data_a,
	output word_t    rd_data_b,
	input  logic     wr_en,
	input  reg_idx_t wr_addr,
	input  word_t    wr_data
);

	word_t regs [0:`REG_N-1];

	// r0 is never written, so it stays at its reset value
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `REG_N; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && (wr_addr != '0)) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// Combinational reads
	always_comb begin
		rd_data_a = (rd_addr_a == '0) ? '0 : regs[rd_addr_a];
		rd_data_b = (rd_addr_b == '0) ? '0 : regs[rd_addr_b];
	end

endmodule

// File: hw/alu_ctrl.sv
/* Instruction decoder */
`timescale 1ns/1ns
`include "exec_params.svh"

module alu_ctrl import exec_pkg::*; (
	input  word_t    instr,
	input  logic     instr_valid,
	input  logic     squash,
	input  logic     z,
	output reg_idx_t rd_addr_a,
	output reg_idx_t rd_addr_b,
	input  word_t    rd_data_a,
	input  word_t    rd_data_b,
	output opcode_e  opcode,
	output alu_op_e  ops,
	output word_t    src1,
	output word_t    src0,
	output shamt_t   shamt,
	output logic     flag_hold,
	output logic     wr_en,
	output reg_idx_t wr_addr
);

	reg_idx_t rd;
	reg_idx_t rs;
	reg_idx_t rt;
	logic [`IMM_W-1:0] imm;
	logic writes_rd;

	assign opcode = opcode_e'(instr[`OPC_MSB:`OPC_LSB]);
	assign rd = instr[`RD_MSB:`RD_LSB];
	assign rs = instr[`RS_MSB:`RS_LSB];
	assign rt = instr[`RT_MSB:`RT_LSB];
	assign imm = instr[`IMM_MSB:`IMM_LSB];
	assign shamt = instr[`SHAMT_MSB:`SHAMT_LSB];

	// LHB keeps the low byte of rd, so port b reads rd instead of rt
	assign rd_addr_a = rs;
	assign rd_addr_b = (opcode == OP_LHB) ? rd : rt;

	// An empty or squashed slot holds the flags and writes nothing
	assign flag_hold = squash | ~instr_valid;
	assign wr_en = writes_rd & ~flag_hold;
	assign wr_addr = rd;

	always_comb begin
		ops = ADD16;
		src1 = rd_data_a;
		src0 = rd_data_b;
		writes_rd = 1'b0;
		case (opcode)
			OP_ADD: writes_rd = 1'b1;
			// Conditional add, written back only while Z is set
			OP_ADDZ: writes_rd = z;
			OP_SUB: begin
				ops = SUB16;
				writes_rd = 1'b1;
			end
			OP_AND: begin
				ops = AND16;
				writes_rd = 1'b1;
			end
			OP_NOR: begin
				ops = NOR16;
				writes_rd = 1'b1;
			end
			OP_SLL, OP_SRL, OP_SRA: begin
				ops = (opcode == OP_SLL) ? SLL16 : (opcode == OP_SRL) ? SRL16 : SRA16;
				src0 = '0;
				writes_rd = 1'b1;
			end
			OP_LHB: begin
				ops = LHB16;
				src1 = {{(`DATA_W-`IMM_W){1'b0}}, imm};
				writes_rd = 1'b1;
			end
			// Sign-extended immediate plus zero
			OP_LLB: begin
				src1 = '0;
				src0 = {{(`DATA_W-`IMM_W){imm[`IMM_W-1]}}, imm};
				writes_rd = 1'b1;
			end
			// Memory, control flow and halt retire as no-ops
			default: begin
				src1 = '0;
				src0 = '0;
			end
		endcase
	end

endmodule

// File: hw/alu.sv
/* Saturating 16-bit ALU */
`timescale 1ns/1ns
`include "exec_params.svh"

module alu import exec_pkg::*; (
	input  logic    clk,
	input  logic    rst_n,
	input  opcode_e opcode,
	input  alu_op_e ops,
	input  word_t   src1,
	input  word_t   src0,
	input  shamt_t  shamt,
	input  logic    flag_hold,
	output word_t   dst,
	output logic    n,
	output logic    z,
	output logic    v
);

	localparam word_t SAT_POS = {1'b0, {(`DATA_W-1){1'b1}}};
	localparam word_t SAT_NEG = {1'b1, {(`DATA_W-1){1'b0}}};

	word_t arith_raw;
	word_t arith_sat;
	logic  a_sgn;
	logic  b_sgn;
	logic  r_sgn;
	logic  ov_pos;
	logic  ov_neg;
	logic  update_nzv;
	logic  update_z_only;

	assign arith_raw = (ops == SUB16) ? (src1 - src0) : (src1 + src0);

	assign a_sgn = src1[`DATA_W-1];
	assign b_sgn = src0[`DATA_W-1];
	assign r_sgn = arith_raw[`DATA_W-1];

	// Overflow from operand signs against the sign of the raw result
	always_comb begin
		ov_pos = 1'b0;
		ov_neg = 1'b0;
		if (ops == ADD16) begin
			ov_pos = ~a_sgn & ~b_sgn & r_sgn;
			ov_neg = a_sgn & b_sgn & ~r_sgn;
		end else if (ops == SUB16) begin
			ov_pos = ~a_sgn & b_sgn & r_sgn;
			ov_neg = a_sgn & ~b_sgn & ~r_sgn;
		end
	end

	assign arith_sat = ov_pos ? SAT_POS : ov_neg ? SAT_NEG : arith_raw;

	always_comb begin
		case (ops)
			ADD16, SUB16: dst = arith_sat;
			AND16: dst = src1 & src0;
			NOR16: dst = ~(src1 | src0);
			SLL16: dst = src1 << shamt;
			SRL16: dst = src1 >> shamt;
			SRA16: dst = word_t'($signed(src1) >>> shamt);
			// Immediate byte on top of the low byte of rd
			LHB16: dst = {src1[7:0], src0[7:0]};
			default: dst = '0;
		endcase
	end

	// Flag update classes by opcode
	assign update_nzv = (opcode == OP_ADD) || (opcode == OP_ADDZ) || (opcode == OP_SUB);
	assign update_z_only = (opcode == OP_AND) || (opcode == OP_NOR) ||
		(opcode == OP_SLL) || (opcode == OP_SRL) || (opcode == OP_SRA);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			n <= 1'b0;
			z <= 1'b0;
			v <= 1'b0;
		end else if (!flag_hold) begin
			if (update_nzv) begin
				n <= dst[`DATA_W-1];
				z <= (dst == '0);
				v <= ov_pos | ov_neg;
			end else if (update_z_only) begin
				z <= (dst == '0);
			end
		end
	end

endmodule

// File: hw/exec_top.sv
/* Execute stage top */
`timescale 1ns/1ns

module exec_top import exec_pkg::*; (
	input  logic  clk,
	input  logic  rst_n,
	input  word_t instr,
	input  logic  instr_valid,
	input  logic  squash,
	output word_t result,
	output logic  result_valid,
	output logic  n,
	output logic  z,
	output logic  v
);

	reg_idx_t rd_addr_a;
	reg_idx_t rd_addr_b;
	word_t    rd_data_a;
	word_t    rd_data_b;
	opcode_e  opcode;
	alu_op_e  ops;
	word_t    src1;
	word_t    src0;
	shamt_t   shamt;
	logic     flag_hold;
	logic     wr_en;
	reg_idx_t wr_addr;
	word_t    dst;

	alu_ctrl u_alu_ctrl (
		.instr       (instr),
		.instr_valid (instr_valid),
		.squash      (squash),
		.z           (z),
		.rd_addr_a   (rd_addr_a),
		.rd_addr_b   (rd_addr_b),
		.rd_data_a   (rd_data_a),
		.rd_data_b   (rd_data_b),
		.opcode      (opcode),
		.ops         (ops),
		.src1        (src1),
		.src0        (src0),
		.shamt       (shamt),
		.flag_hold   (flag_hold),
		.wr_en       (wr_en),
		.wr_addr     (wr_addr)
	);

	reg_file u_reg_file (
		.clk       (clk),
		.rst_n     (rst_n),
		.rd_addr_a (rd_addr_a),
		.rd_addr_b (rd_addr_b),
		.rd_data_a (rd_data_a),
		.rd_data_b (rd_data_b),
		.wr_en     (wr_en),
		.wr_addr   (wr_addr),
		.wr_data   (dst)
	);

	alu u_alu (
		.clk       (clk),
		.rst_n     (rst_n),
		.opcode    (opcode),
		.ops       (ops),
		.src1      (src1),
		.src0      (src0),
		.shamt     (shamt),
		.flag_hold (flag_hold),
		.dst       (dst),
		.n         (n),
		.z         (z),
		.v         (v)
	);

	// Result follows every write, a write to r0 included
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			result <= '0;
			result_valid <= 1'b0;
		end else begin
			result_valid <= wr_en;
			if (wr_en) begin
				result <= dst;
			end
		end
	end

endmodule

// File: verif/exec_assertions.sv
/* Execute stage assertions */
`timescale 1ns/1ns
`include "exec_params.svh"

module exec_assertions import exec_pkg::*; (
	input logic  clk,
	input logic  rst_n,
	input word_t instr,
	input logic  instr_valid,
	input logic  squash,
	input logic  result_valid,
	input logic  n,
	input logic  z,
	input logic  v
);

	opcode_e op;
	logic    flags_kept;
	logic    no_result;
	int      fail_count = 0;

	assign op = opcode_e'(instr[`OPC_MSB:`OPC_LSB]);
	assign no_result = op inside {OP_LW, OP_SW, OP_B, OP_JAL, OP_JR, OP_HLT};
	assign flags_kept = no_result || (op == OP_LHB) || (op == OP_LLB);

	// A result only follows a live slot
	a_valid_live: assert property (@(posedge clk) disable iff (!rst_n)
		result_valid |-> $past(instr_valid && !squash))
		else begin
			fail_count++;
			$error("result_valid without a live instruction");
		end

	a_flags_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(squash || !instr_valid || flags_kept) |=> ($stable(n) && $stable(z) && $stable(v)))
		else begin
			fail_count++;
			$error("flags changed on a dead slot or a flag-neutral opcode");
		end

	a_noop_quiet: assert property (@(posedge clk) disable iff (!rst_n)
		no_result |=> !result_valid)
		else begin
			fail_count++;
			$error("no-op opcode produced a result");
		end

	// Z-only class keeps N and V
	a_z_only: assert property (@(posedge clk) disable iff (!rst_n)
		(op inside {OP_AND, OP_NOR, OP_SLL, OP_SRL, OP_SRA}) |=> ($stable(n) && $stable(v)))
		else begin
			fail_count++;
			$error("N or V changed on a Z-only opcode");
		end

endmodule

bind exec_top exec_assertions u_exec_assertions (
	.clk          (clk),
	.rst_n        (rst_n),
	.instr        (instr),
	.instr_valid  (instr_valid),
	.squash       (squash),
	.result_valid (result_valid),
	.n            (n),
	.z            (z),
	.v            (v)
);

// File: verif/exec_tb.sv
/* Execute stage testbench */
`timescale 1ns/1ns
`include "exec_params.svh"

module exec_tb import exec_pkg::*; ();

	localparam int CLK_PERIOD = 10;
	localparam int NUM_RAND = 2000;
	localparam int WATCHDOG_NS = (NUM_RAND + 200) * CLK_PERIOD;

	logic  clk;
	logic  rst_n;
	word_t instr;
	logic  instr_valid;
	logic  squash;
	word_t result;
	logic  result_valid;
	logic  n;
	logic  z;
	logic  v;

	integer seed = 94;
	int word_errs;
	int flag_errs;
	int valid_errs;
	int assert_errs;

	// Reference model state
	word_t m_regs [0:`REG_N-1];
	word_t m_result;
	logic  m_valid;
	logic  m_n;
	logic  m_z;
	logic  m_v;
	string last_name;

	exec_top UUT (
		.clk          (clk),
		.rst_n        (rst_n),
		.instr        (instr),
		.instr_valid  (instr_valid),
		.squash       (squash),
		.result       (result),
		.result_valid (result_valid),
		.n            (n),
		.z            (z),
		.v            (v)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic compare_word(input string name, input word_t exp, input word_t act);
		if (act !== exp) begin
			$display("FAILED %s: expected %h, actual %h", name, exp, act);
			word_errs++;
		end
	endtask

	task automatic compare_flags(input string name, input logic [2:0] exp, input logic [2:0] act);
		if (act !== exp) begin
			$display("FAILED %s: expected nzv=%b, actual nzv=%b", name, exp, act);
			flag_errs++;
		end
	endtask

	task automatic compare_valid(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("FAILED %s: expected %b, actual %b", name, exp, act);
			valid_errs++;
		end
	endtask

	function automatic string name_of(input opcode_e op, input logic vld, input logic sq);
		if (!vld)
			return "idle";
		if (sq)
			return "squash";
		case (op)
			OP_ADD, OP_SUB: return "arith";
			OP_ADDZ: return "addz";
			OP_AND, OP_NOR: return "logic";
			OP_SLL, OP_SRL, OP_SRA: return "shift";
			OP_LHB, OP_LLB: return "load_imm";
			default: return "noop";
		endcase
	endfunction

	function automatic word_t enc(input opcode_e op, input int rd, input int rs, input int rt);
		return {op, rd[3:0], rs[3:0], rt[3:0]};
	endfunction

	function automatic word_t enc_imm(input opcode_e op, input int rd, input int imm);
		return {op, rd[3:0], imm[7:0]};
	endfunction

	// Opcodes weighted toward the ALU group, fields fully random
	function automatic word_t random_instr();
		int k;
		int j;
		word_t r;
		opcode_e op;
		k = {$random(seed)} % 20;
		j = {$random(seed)} % 6;
		r = $random(seed);
		if (k < 16)
			op = (k % 10 < 8) ? opcode_e'(4'(k % 10)) : opcode_e'(4'(k % 10 + 2));
		else
			op = opcode_e'(4'((j < 2) ? 8 + j : 10 + j));
		return {op, r[11:0]};
	endfunction

	// Expected state after the next rising edge
	task automatic apply_model(input word_t ins, input logic vld, input logic sq);
		opcode_e op;
		reg_idx_t rd;
		word_t a;
		word_t b;
		word_t d;
		int sa;
		int sb;
		int s;
		logic wr;
		logic ovf;
		logic upd_nzv;
		logic upd_z;
		op = opcode_e'(ins[`OPC_MSB:`OPC_LSB]);
		rd = ins[`RD_MSB:`RD_LSB];
		a = m_regs[ins[`RS_MSB:`RS_LSB]];
		b = m_regs[ins[`RT_MSB:`RT_LSB]];
		d = '0;
		wr = 1'b1;
		ovf = 1'b0;
		upd_nzv = 1'b0;
		upd_z = 1'b0;
		case (op)
			OP_ADD, OP_ADDZ, OP_SUB: begin
				sa = $signed(a);
				sb = $signed(b);
				s = (op == OP_SUB) ? sa - sb : sa + sb;
				ovf = (s > 32767) || (s < -32768);
				d = (s > 32767) ? 16'h7FFF : (s < -32768) ? 16'h8000 : word_t'(s);
				if (op == OP_ADDZ)
					wr = m_z;
				upd_nzv = 1'b1;
			end
			OP_AND: {d, upd_z} = {a & b, 1'b1};
			OP_NOR: {d, upd_z} = {~(a | b), 1'b1};
			OP_SLL: {d, upd_z} = {a << ins[3:0], 1'b1};
			OP_SRL: {d, upd_z} = {a >> ins[3:0], 1'b1};
			OP_SRA: {d, upd_z} = {word_t'($signed(a) >>> ins[3:0]), 1'b1};
			OP_LHB: d = {ins[7:0], m_regs[rd][7:0]};
			OP_LLB: d = {{8{ins[7]}}, ins[7:0]};
			default: wr = 1'b0;
		endcase
		last_name = name_of(op, vld, sq);
		m_valid = wr && vld && !sq;
		if (vld && !sq) begin
			if (upd_nzv)
				{m_n, m_z, m_v} = {d[15], d == 16'h0000, ovf};
			else if (upd_z)
				m_z = (d == 16'h0000);
			if (wr) begin
				m_result = d;
				if (rd != 0)
					m_regs[rd] = d;
			end
		end
	endtask

	task automatic check_outputs();
		compare_valid({last_name, " valid"}, m_valid, result_valid);
		compare_word({last_name, " result"}, m_result, result);
		compare_flags({last_name, " flags"}, {m_n, m_z, m_v}, {n, z, v});
	endtask

	// Check the previous slot, then present the next one
	task automatic step(input word_t ins, input logic vld, input logic sq);
		@(negedge clk);
		check_outputs();
		instr = ins;
		instr_valid = vld;
		squash = sq;
		apply_model(ins, vld, sq);
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
		$display("FAIL: see errors above");
		$finish;
	end

	initial begin
		word_t ins;
		logic vld;
		logic sq;
		clk = 1'b0;
		rst_n = 1'b0;
		instr = '0;
		instr_valid = 1'b0;
		squash = 1'b0;
		{word_errs, flag_errs, valid_errs, assert_errs} = '0;
		{m_result, m_valid, m_n, m_z, m_v} = '0;
		for (int i = 0; i < `REG_N; i++)
			m_regs[i] = '0;
		last_name = "reset";
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		// Extreme operands for saturation
		step(enc_imm(OP_LLB, 1, 8'hFF), 1, 0);
		step(enc_imm(OP_LHB, 1, 8'h7F), 1, 0);
		step(enc_imm(OP_LHB, 2, 8'h80), 1, 0);
		step(enc_imm(OP_LLB, 3, 8'h01), 1, 0);
		step(enc_imm(OP_LLB, 4, 8'hFF), 1, 0);
		step(enc(OP_ADD, 5, 1, 3), 1, 0);
		step(enc(OP_ADD, 6, 2, 4), 1, 0);
		step(enc(OP_SUB, 7, 1, 4), 1, 0);
		step(enc(OP_SUB, 8, 2, 3), 1, 0);
		// ADDZ with Z set, then with Z clear
		step(enc(OP_SUB, 9, 3, 3), 1, 0);
		step(enc(OP_ADDZ, 10, 1, 0), 1, 0);
		step(enc(OP_ADDZ, 11, 3, 0), 1, 0);
		// r0 write, squashed slot, halt
		step(enc_imm(OP_LLB, 0, 8'h55), 1, 0);
		step(enc(OP_ADD, 12, 0, 0), 1, 0);
		step(enc(OP_SUB, 1, 3, 3), 1, 1);
		step(enc(OP_HLT, 1, 0, 0), 1, 0);
		step(enc(OP_ADD, 13, 1, 0), 1, 0);
		for (int i = 0; i < NUM_RAND; i++) begin
			ins = random_instr();
			vld = ({$random(seed)} % 8) != 0;
			sq = ({$random(seed)} % 10) == 0;
			step(ins, vld, sq);
		end
		// Read back every register through r0
		for (int i = 0; i < `REG_N; i++)
			step(enc(OP_ADD, 0, i, 0), 1, 0);
		step('0, 0, 0);
		assert_errs = UUT.u_exec_assertions.fail_count;
		$display("Errors: %0d result, %0d flags, %0d valid, %0d assertion",
			word_errs, flag_errs, valid_errs, assert_errs);
		if (word_errs + flag_errs + valid_errs + assert_errs == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

// File: files.f
+incdir+hw
hw/exec_pkg.sv
hw/reg_file.sv
hw/alu_ctrl.sv
hw/alu.sv
hw/exec_top.sv
verif/exec_assertions.sv
verif/exec_tb.sv

// File: Bender.yml
package:
  name: exec_stage

sources:
  - include_dirs:
      - hw
    files:
      - hw/exec_pkg.sv
      - hw/reg_file.sv
      - hw/alu_ctrl.sv
      - hw/alu.sv
      - hw/exec_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - verif/exec_assertions.sv
      - verif/exec_tb.sv
